//--- rtl/spiLinkPkg.sv
// Command codes follow the SPI header byte; unknown codes move no data
`default_nettype none

package spiLinkPkg;

	// ------------------------------
	// Header command byte, low 3 bits
	// ------------------------------
	typedef enum logic [2:0]
	{
		// No transfer
		CMD_NONE   = 3'd0,
		// Single CSR word
		CMD_CSR_WR = 3'd1,
		CMD_CSR_RD = 3'd2,
		// Burst of length/4 RAM words
		CMD_RAM_WR = 3'd3,
		CMD_RAM_RD = 3'd4
	} spiCmd_t;

	// ------------------------------
	// Target region on Wishbone
	// ------------------------------
	// Sits in the top address bit
	typedef enum logic
	{
		REGION_CSR = 1'b0,
		REGION_RAM = 1'b1
	} memRegion_t;

endpackage

`default_nettype wire

//--- rtl/spiLinkTop.sv
// SPI mode 0 slave into CSR and RAM; SCK half period at least 8 iSCLK cycles, no SPI flow control
`timescale 1ns/100ps
`default_nettype none

`include "spiLink_config.svh"

module spiLinkTop
(
	input  wire                            iSCLK,
	input  wire                            iSRST,
	input  wire                            spiSck,
	input  wire                            spiMosi,
	input  wire                            spiCs,
	output wire                            spiMiso,
	output wire [`SPI_LINK_WORD_BITS-1:0]  csrCtrl,
	output wire                            opDone
);

	// ------------------------------
	// Front end to bridge
	// ------------------------------
	wire                             hdrValid;
	wire [`SPI_LINK_WORD_BITS-1:0]   hdrAddr;
	spiLinkPkg::spiCmd_t             hdrCmd;
	wire [15:0]                      hdrLen;
	wire                             rxValid;
	wire [`SPI_LINK_WORD_BITS-1:0]   rxWord;
	wire                             frameEnd;
	wire [`SPI_LINK_WORD_BITS-1:0]   txWord;
	wire                             txReady;
	// Bridge to memory
	wire                             wbCyc;
	wire                             wbStb;
	wire                             wbWe;
	wire [`SPI_LINK_WB_ADR_BITS-1:0] wbAdr;
	wire [`SPI_LINK_WORD_BITS-1:0]   wbDatW;
	wire                             wbAck;
	wire [`SPI_LINK_WORD_BITS-1:0]   wbDatR;

	spiSlaveFrontEnd frontEnd0 (
		.iSCLK    (iSCLK),
		.iSRST    (iSRST),
		.spiSck   (spiSck),
		.spiMosi  (spiMosi),
		.spiCs    (spiCs),
		.spiMiso  (spiMiso),
		.hdrValid (hdrValid),
		.hdrAddr  (hdrAddr),
		.hdrCmd   (hdrCmd),
		.hdrLen   (hdrLen),
		.rxValid  (rxValid),
		.rxWord   (rxWord),
		.frameEnd (frameEnd),
		.txWord   (txWord),
		.txReady  (txReady)
	);

	spiWbBridge bridge0 (
		.iSCLK    (iSCLK),
		.iSRST    (iSRST),
		.hdrValid (hdrValid),
		.hdrAddr  (hdrAddr),
		.hdrCmd   (hdrCmd),
		.hdrLen   (hdrLen),
		.rxValid  (rxValid),
		.rxWord   (rxWord),
		.frameEnd (frameEnd),
		.txWord   (txWord),
		.txReady  (txReady),
		.wbCyc    (wbCyc),
		.wbStb    (wbStb),
		.wbWe     (wbWe),
		.wbAdr    (wbAdr),
		.wbDatW   (wbDatW),
		.wbAck    (wbAck),
		.wbDatR   (wbDatR),
		.opDone   (opDone)
	);

	// CSR bank and RAM behind Wishbone
	wbWordMemory memory0 (
		.iSCLK    (iSCLK),
		.iSRST    (iSRST),
		.wbCyc    (wbCyc),
		.wbStb    (wbStb),
		.wbWe     (wbWe),
		.wbAdr    (wbAdr),
		.wbDatW   (wbDatW),
		.wbAck    (wbAck),
		.wbDatR   (wbDatR),
		.csrCtrl  (csrCtrl)
	);

endmodule

`default_nettype wire

//--- rtl/spiLink_config.svh
// Sizes for the SPI link; CSR depth must not exceed RAM depth, and RAM length is clamped to MAX_BYTES
`ifndef SPI_LINK_CONFIG_SVH
`define SPI_LINK_CONFIG_SVH

// ------------------------------
// Data path
// ------------------------------
// Width of one SPI data word and one Wishbone word
`define SPI_LINK_WORD_BITS 32

// ------------------------------
// Memory map
// ------------------------------
// CSR bank depth in words, index taken modulo this depth
`define SPI_LINK_CSR_WORDS 16
// RAM depth in words, addresses wrap modulo this depth
`define SPI_LINK_RAM_WORDS 256
// Largest RAM transfer in bytes
`define SPI_LINK_MAX_BYTES 4096
// Wishbone address, region bit on top of the RAM index
`define SPI_LINK_WB_ADR_BITS ($clog2(`SPI_LINK_RAM_WORDS) + 1)

`endif

//--- rtl/spiSlaveFrontEnd.sv
// SPI mode 0 slave only; SCK half period must be at least 8 iSCLK cycles, MSB first, 32-bit words
`timescale 1ns/100ps
`default_nettype none

`include "spiLink_config.svh"

module spiSlaveFrontEnd
(
	input  wire                            iSCLK,
	input  wire                            iSRST,
	// SPI pins
	input  wire                            spiSck,
	input  wire                            spiMosi,
	input  wire                            spiCs,
	output wire                            spiMiso,
	// Header toward the bridge
	output logic                           hdrValid,
	output logic [`SPI_LINK_WORD_BITS-1:0] hdrAddr,
	output spiLinkPkg::spiCmd_t            hdrCmd,
	output logic [15:0]                    hdrLen,
	// Received data words
	output logic                           rxValid,
	output logic [`SPI_LINK_WORD_BITS-1:0] rxWord,
	output logic                           frameEnd,
	// Next word for MISO
	input  wire  [`SPI_LINK_WORD_BITS-1:0] txWord,
	input  wire                            txReady
);

	localparam int WORD_BITS = `SPI_LINK_WORD_BITS;
	localparam int CNT_BITS  = $clog2(WORD_BITS);

	typedef enum logic [1:0] {FE_ADDR, FE_CMD, FE_DATA} feState_t;

	feState_t             state;
	logic [1:0]           sckSync;
	logic [1:0]           mosiSync;
	logic [1:0]           csSync;
	logic                 sckDly;
	logic                 csDly;
	logic                 sckRise;
	logic                 sckFall;
	logic                 wordDone;
	logic                 firstPending;
	logic [CNT_BITS-1:0]  bitCnt;
	logic [WORD_BITS-1:0] shiftIn;
	logic [WORD_BITS-1:0] misoShift;

	// ------------------------------
	// Pin synchronizer and edges
	// ------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			sckSync  <= 2'b00;
			mosiSync <= 2'b00;
			csSync   <= 2'b11;
			sckDly   <= 1'b0;
			csDly    <= 1'b1;
			frameEnd <= 1'b0;
		end
		else
		begin
			sckSync  <= {sckSync[0], spiSck};
			mosiSync <= {mosiSync[0], spiMosi};
			csSync   <= {csSync[0], spiCs};
			// Edge register behind the two sync flops
			sckDly   <= sckSync[1];
			csDly    <= csSync[1];
			// Chip select rising ends the frame
			frameEnd <= csSync[1] & ~csDly;
		end
	end

	// SCK edges count only inside a frame
	assign sckRise  = ~csSync[1] & sckSync[1] & ~sckDly;
	assign sckFall  = ~csSync[1] & ~sckSync[1] & sckDly;
	// Falling edge after the last bit of a word
	assign wordDone = sckFall && (bitCnt == CNT_BITS'(WORD_BITS - 1));

	// MOSI sampled on rising edges
	always_ff @(posedge iSCLK)
	begin
		if (sckRise)
		begin
			shiftIn <= {shiftIn[WORD_BITS-2:0], mosiSync[1]};
		end
	end

	// ------------------------------
	// Header and data deframing
	// ------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state    <= FE_ADDR;
			bitCnt   <= '0;
			hdrValid <= 1'b0;
			rxValid  <= 1'b0;
			hdrCmd   <= spiLinkPkg::CMD_NONE;
		end
		else
		begin
			hdrValid <= wordDone && (state == FE_CMD);
			rxValid  <= wordDone && (state == FE_DATA);
			if (csSync[1])
			begin
				// Idle or aborted frame restarts at the address
				state  <= FE_ADDR;
				bitCnt <= '0;
			end
			else if (sckFall)
			begin
				bitCnt <= bitCnt + 1'b1;
				if (wordDone && (state == FE_ADDR))
				begin
					state <= FE_CMD;
				end
				else if (wordDone && (state == FE_CMD))
				begin
					state  <= FE_DATA;
					// Dummy byte in [31:24] is dropped
					hdrCmd <= spiLinkPkg::spiCmd_t'(shiftIn[18:16]);
				end
			end
		end
	end

	// Header payload, held until the next header
	always_ff @(posedge iSCLK)
	begin
		if (wordDone && (state == FE_ADDR))
		begin
			hdrAddr <= shiftIn;
		end
		if (wordDone && (state == FE_CMD))
		begin
			hdrLen <= shiftIn[15:0];
		end
		if (wordDone && (state == FE_DATA))
		begin
			rxWord <= shiftIn;
		end
	end

	// ------------------------------
	// MISO shift-out
	// ------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			misoShift    <= '1;
			firstPending <= 1'b0;
		end
		else if (csSync[1])
		begin
			// Line parks high outside a frame
			misoShift    <= '1;
			firstPending <= 1'b0;
		end
		else if (wordDone && (state != FE_ADDR))
		begin
			misoShift    <= txReady ? txWord : '1;
			// First data word may land after the header ends
			firstPending <= (state == FE_CMD);
		end
		else if (firstPending && txReady)
		begin
			misoShift    <= txWord;
			firstPending <= 1'b0;
		end
		else
		begin
			if (sckRise)
			begin
				firstPending <= 1'b0;
			end
			if (sckFall && (state == FE_DATA))
			begin
				misoShift <= {misoShift[WORD_BITS-2:0], 1'b1};
			end
		end
	end

	assign spiMiso = misoShift[WORD_BITS-1];

	// Header and data strobes come from different phases
	hdrRxExclusive: assert property (@(posedge iSCLK) disable iff (iSRST)
		!(hdrValid && rxValid))
		else $error("hdrValid and rxValid high together");

endmodule

`default_nettype wire

//--- rtl/spiWbBridge.sv
// Assumes the SPI side never delivers a word while a Wishbone cycle is open; budget is fixed per header
`timescale 1ns/100ps
`default_nettype none

`include "spiLink_config.svh"

module spiWbBridge
(
	input  wire                              iSCLK,
	input  wire                              iSRST,
	// Front end
	input  wire                              hdrValid,
	input  wire  [`SPI_LINK_WORD_BITS-1:0]   hdrAddr,
	input  spiLinkPkg::spiCmd_t              hdrCmd,
	input  wire  [15:0]                      hdrLen,
	input  wire                              rxValid,
	input  wire  [`SPI_LINK_WORD_BITS-1:0]   rxWord,
	input  wire                              frameEnd,
	output logic [`SPI_LINK_WORD_BITS-1:0]   txWord,
	output logic                             txReady,
	// Wishbone classic master
	output logic                             wbCyc,
	output logic                             wbStb,
	output logic                             wbWe,
	output logic [`SPI_LINK_WB_ADR_BITS-1:0] wbAdr,
	output logic [`SPI_LINK_WORD_BITS-1:0]   wbDatW,
	input  wire                              wbAck,
	input  wire  [`SPI_LINK_WORD_BITS-1:0]   wbDatR,
	output logic                             opDone
);

	localparam int WORD_BITS   = `SPI_LINK_WORD_BITS;
	localparam int IDX_BITS    = `SPI_LINK_WB_ADR_BITS - 1;
	localparam int BUDGET_BITS = $clog2(`SPI_LINK_MAX_BYTES / 4) + 1;

	typedef enum logic [1:0] {BR_IDLE, BR_READY, BR_BUS, BR_HOLD} brState_t;

	brState_t               state;
	spiLinkPkg::spiCmd_t    cmd;
	spiLinkPkg::memRegion_t region;
	spiLinkPkg::memRegion_t hdrRegion;
	logic [WORD_BITS-1:0]   curAddr;
	logic [BUDGET_BITS-1:0] budget;
	logic [BUDGET_BITS-1:0] hdrBudget;
	logic [BUDGET_BITS-1:0] wordCnt;
	logic [BUDGET_BITS-1:0] nextCnt;
	logic [15:0]            lenClamped;
	logic                   isRead;
	logic                   hdrIsRead;
	logic                   closing;

	// ------------------------------
	// Word budget from the header
	// ------------------------------
	assign lenClamped = (hdrLen > 16'(`SPI_LINK_MAX_BYTES)) ? 16'(`SPI_LINK_MAX_BYTES) : hdrLen;
	assign hdrIsRead  = (hdrCmd == spiLinkPkg::CMD_CSR_RD) || (hdrCmd == spiLinkPkg::CMD_RAM_RD);
	assign isRead     = (cmd == spiLinkPkg::CMD_CSR_RD) || (cmd == spiLinkPkg::CMD_RAM_RD);
	assign nextCnt    = wordCnt + 1'b1;

	always_comb
	begin
		hdrRegion = spiLinkPkg::REGION_RAM;
		hdrBudget = '0;
		case (hdrCmd)
			spiLinkPkg::CMD_CSR_WR, spiLinkPkg::CMD_CSR_RD:
			begin
				// CSR ignores the length field
				hdrRegion = spiLinkPkg::REGION_CSR;
				hdrBudget = BUDGET_BITS'(1);
			end
			spiLinkPkg::CMD_RAM_WR, spiLinkPkg::CMD_RAM_RD:
			begin
				// Whole words only, remainder bytes dropped
				hdrBudget = lenClamped[BUDGET_BITS+1:2];
			end
			default:
			begin
				hdrBudget = '0;
			end
		endcase
	end

	// ------------------------------
	// Command sequencer
	// ------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state   <= BR_IDLE;
			cmd     <= spiLinkPkg::CMD_NONE;
			region  <= spiLinkPkg::REGION_CSR;
			curAddr <= '0;
			budget  <= '0;
			wordCnt <= '0;
			closing <= 1'b0;
			wbCyc   <= 1'b0;
			wbStb   <= 1'b0;
			wbWe    <= 1'b0;
			wbAdr   <= '0;
			wbDatW  <= '0;
			txWord  <= '0;
			txReady <= 1'b0;
			opDone  <= 1'b0;
		end
		else
		begin
			opDone <= 1'b0;
			case (state)
				BR_IDLE, BR_READY:
				begin
					if (hdrValid)
					begin
						cmd     <= hdrCmd;
						region  <= hdrRegion;
						curAddr <= hdrAddr;
						budget  <= hdrBudget;
						wordCnt <= '0;
						closing <= 1'b0;
						txReady <= 1'b0;
						state   <= BR_READY;
						// Reads prefetch the first word right away
						if (hdrIsRead && (hdrBudget != '0))
						begin
							wbCyc <= 1'b1;
							wbStb <= 1'b1;
							wbWe  <= 1'b0;
							wbAdr <= {hdrRegion, hdrAddr[IDX_BITS-1:0]};
							state <= BR_BUS;
						end
					end
					else if (frameEnd)
					begin
						txReady <= 1'b0;
						state   <= BR_IDLE;
					end
					else if (rxValid && (state == BR_READY))
					begin
						if (wordCnt != budget)
						begin
							// Write of the new word, or prefetch of the next read
							wbCyc  <= 1'b1;
							wbStb  <= 1'b1;
							wbWe   <= ~isRead;
							wbAdr  <= {region, curAddr[IDX_BITS-1:0]};
							wbDatW <= rxWord;
							state  <= BR_BUS;
						end
						else
						begin
							// Budget used up, MISO gets all ones
							txReady <= 1'b0;
						end
					end
				end
				BR_BUS:
				begin
					if (frameEnd)
					begin
						closing <= 1'b1;
					end
					if (wbAck)
					begin
						wbCyc   <= 1'b0;
						wbStb   <= 1'b0;
						curAddr <= curAddr + 1'b1;
						wordCnt <= nextCnt;
						opDone  <= (nextCnt == budget);
						if (isRead)
						begin
							txWord  <= wbDatR;
							txReady <= 1'b1;
						end
						if (closing || frameEnd)
						begin
							txReady <= 1'b0;
							state   <= BR_IDLE;
						end
						else if (isRead && (wordCnt == '0))
						begin
							// Give the front end one cycle to take word 0
							state <= BR_HOLD;
						end
						else
						begin
							state <= BR_READY;
						end
					end
				end
				BR_HOLD:
				begin
					if (frameEnd)
					begin
						txReady <= 1'b0;
						state   <= BR_IDLE;
					end
					else if (wordCnt != budget)
					begin
						wbCyc <= 1'b1;
						wbStb <= 1'b1;
						wbWe  <= 1'b0;
						wbAdr <= {region, curAddr[IDX_BITS-1:0]};
						state <= BR_BUS;
					end
					else
					begin
						state <= BR_READY;
					end
				end
				default:
				begin
					state <= BR_IDLE;
				end
			endcase
		end
	end

	// SPI cannot stall, each word must find the bus free
	rxOutsideCycle: assert property (@(posedge iSCLK) disable iff (iSRST)
		rxValid |-> !wbCyc)
		else $error("rxValid during an open Wishbone cycle");

	stbInsideCyc: assert property (@(posedge iSCLK) disable iff (iSRST)
		wbStb |-> wbCyc)
		else $error("wbStb without wbCyc");

endmodule

`default_nettype wire

//--- rtl/wbWordMemory.sv
// Single-cycle registered ack, one access per cycle; CSR index wraps modulo 16, RAM modulo 256
`timescale 1ns/100ps
`default_nettype none

`include "spiLink_config.svh"

module wbWordMemory
(
	input  wire                              iSCLK,
	input  wire                              iSRST,
	// Wishbone classic target
	input  wire                              wbCyc,
	input  wire                              wbStb,
	input  wire                              wbWe,
	input  wire  [`SPI_LINK_WB_ADR_BITS-1:0] wbAdr,
	input  wire  [`SPI_LINK_WORD_BITS-1:0]   wbDatW,
	output logic                             wbAck,
	output logic [`SPI_LINK_WORD_BITS-1:0]   wbDatR,
	// CSR word 0 for fabric control
	output wire  [`SPI_LINK_WORD_BITS-1:0]   csrCtrl
);

	localparam int WORD_BITS    = `SPI_LINK_WORD_BITS;
	localparam int ADR_BITS     = `SPI_LINK_WB_ADR_BITS;
	localparam int CSR_IDX_BITS = $clog2(`SPI_LINK_CSR_WORDS);
	localparam int RAM_IDX_BITS = $clog2(`SPI_LINK_RAM_WORDS);

	logic [WORD_BITS-1:0]    csrBank  [`SPI_LINK_CSR_WORDS];
	logic [WORD_BITS-1:0]    ramArray [`SPI_LINK_RAM_WORDS];
	spiLinkPkg::memRegion_t  region;
	logic [CSR_IDX_BITS-1:0] csrIdx;
	logic [RAM_IDX_BITS-1:0] ramIdx;
	logic                    accessReq;

	// ------------------------------
	// Address decode
	// ------------------------------
	assign region    = spiLinkPkg::memRegion_t'(wbAdr[ADR_BITS-1]);
	// Low bits only, so indices wrap
	assign csrIdx    = wbAdr[CSR_IDX_BITS-1:0];
	assign ramIdx    = wbAdr[RAM_IDX_BITS-1:0];
	// Ack cycle itself is not a new request
	assign accessReq = wbCyc & wbStb & ~wbAck;

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			wbAck <= 1'b0;
		end
		else
		begin
			wbAck <= accessReq;
		end
	end

	// ------------------------------
	// Storage and read data
	// ------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			// Both banks come up zeroed
			for (int i = 0; i < `SPI_LINK_CSR_WORDS; i++)
			begin
				csrBank[i] <= '0;
			end
			for (int j = 0; j < `SPI_LINK_RAM_WORDS; j++)
			begin
				ramArray[j] <= '0;
			end
		end
		else if (accessReq && wbWe)
		begin
			if (region == spiLinkPkg::REGION_CSR)
			begin
				csrBank[csrIdx] <= wbDatW;
			end
			else
			begin
				ramArray[ramIdx] <= wbDatW;
			end
		end
	end

	// Read data lines up with the ack
	always_ff @(posedge iSCLK)
	begin
		if (accessReq && !wbWe)
		begin
			wbDatR <= (region == spiLinkPkg::REGION_CSR) ? csrBank[csrIdx] : ramArray[ramIdx];
		end
	end

	assign csrCtrl = csrBank[0];

	// One ack per cycle, never back to back
	ackSinglePulse: assert property (@(posedge iSCLK) disable iff (iSRST)
		wbAck |=> !wbAck)
		else $error("wbAck high two cycles in a row");

endmodule

`default_nettype wire

//--- runSim.sh
#!/bin/sh
# Build and run the SPI link testbench with Verilator, from the project root

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module spiLinkTb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/VspiLinkTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
	exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0

//--- sim.f
+incdir+rtl
rtl/spiLinkPkg.sv
rtl/spiSlaveFrontEnd.sv
rtl/spiWbBridge.sv
rtl/wbWordMemory.sv
rtl/spiLinkTop.sv
tb/spiLinkChecker.sv
tb/spiLinkTb.sv

//--- tb/spiLinkChecker.sv
// Counts SCK rises per frame, so the first 64 rises are the header; expected values arrive from the driver
`timescale 1ns/100ps
`default_nettype none

`include "spiLink_config.svh"

module spiLinkChecker
(
	input  wire                            iSCLK,
	input  wire                            iSRST,
	// DUT pins and outputs
	input  wire                            spiSck,
	input  wire                            spiCs,
	input  wire                            spiMiso,
	input  wire                            opDone,
	input  wire  [`SPI_LINK_WORD_BITS-1:0] csrCtrl,
	// Expected values from the driver
	input  wire                            expValid,
	input  wire  [`SPI_LINK_WORD_BITS-1:0] expWord,
	input  wire                            doneCheck,
	input  int                             expDone,
	input  wire                            csrCheck,
	input  wire  [`SPI_LINK_WORD_BITS-1:0] expCsr,
	output int                             errorCount,
	output int                             doneCount
);

	localparam int W = `SPI_LINK_WORD_BITS;

	logic         sckPrev;
	int           bitCount;
	logic [W-1:0] misoWord;

	always_ff @(posedge iSCLK)
	begin
		logic [W-1:0] nextWord;
		int           newErrors;
		newErrors = 0;
		nextWord  = {misoWord[W-2:0], spiMiso};
		if (iSRST)
		begin
			sckPrev    <= 1'b0;
			bitCount   <= 0;
			misoWord   <= '0;
			doneCount  <= 0;
			errorCount <= 0;
		end
		else
		begin
			sckPrev <= spiSck;
			if (opDone)
			begin
				doneCount <= doneCount + 1;
			end
			// ------------------------------
			// MISO word rebuild
			// ------------------------------
			if (spiCs)
			begin
				bitCount <= 0;
			end
			else if (spiSck && !sckPrev)
			begin
				misoWord <= nextWord;
				bitCount <= bitCount + 1;
				// Last bit of a data word
				if ((bitCount >= 64) && (((bitCount - 64) % W) == (W - 1)) && expValid)
				begin
					if (nextWord !== expWord)
					begin
						$display("[ERROR] %0t: MISO data word %0d is %h, expected %h",
							$time, (bitCount - 64) / W, nextWord, expWord);
						newErrors++;
					end
				end
			end
			// Counts and control word on request
			if (doneCheck && (doneCount != expDone))
			begin
				$display("[ERROR] %0t: opDone count is %0d, expected %0d",
					$time, doneCount, expDone);
				newErrors++;
			end
			if (csrCheck && (csrCtrl !== expCsr))
			begin
				$display("[ERROR] %0t: csrCtrl is %h, expected %h", $time, csrCtrl, expCsr);
				newErrors++;
			end
			errorCount <= errorCount + newErrors;
		end
	end

endmodule

`default_nettype wire

//--- tb/spiLinkTb.sv
// Runs from the project root so tb/spiLink_testdata.txt resolves; SCK half period fixed at 10 clocks
`timescale 1ns/100ps
`default_nettype none

`include "spiLink_config.svh"

module spiLinkTb;

	localparam int HALF_PERIOD     = 10;
	// Idle SCK between header and data, room for the read prefetch
	localparam int HDR_GAP         = 20;
	localparam int DONE_WAIT       = 400;
	localparam int WATCHDOG_CYCLES = 200000;

	logic                           iSCLK;
	logic                           iSRST;
	logic                           spiSck;
	logic                           spiMosi;
	logic                           spiCs;
	wire                            spiMiso;
	wire  [`SPI_LINK_WORD_BITS-1:0] csrCtrl;
	wire                            opDone;

	// Requests to the checker
	logic                           expValid;
	logic [`SPI_LINK_WORD_BITS-1:0] expWord;
	logic                           doneCheck;
	int                             expDone;
	logic                           csrCheck;
	logic [`SPI_LINK_WORD_BITS-1:0] expCsr;
	int                             checkErrors;
	int                             doneCount;
	int                             driverErrors;
	integer                         seed;
	logic [`SPI_LINK_WORD_BITS-1:0] randQueue [$];

	// ------------------------------
	// Clock and DUT
	// ------------------------------
	initial
	begin
		iSCLK = 1'b0;
		forever #2 iSCLK = ~iSCLK;
	end

	spiLinkTop dut0 (
		.iSCLK   (iSCLK),
		.iSRST   (iSRST),
		.spiSck  (spiSck),
		.spiMosi (spiMosi),
		.spiCs   (spiCs),
		.spiMiso (spiMiso),
		.csrCtrl (csrCtrl),
		.opDone  (opDone)
	);

	spiLinkChecker checker0 (
		.iSCLK      (iSCLK),
		.iSRST      (iSRST),
		.spiSck     (spiSck),
		.spiCs      (spiCs),
		.spiMiso    (spiMiso),
		.opDone     (opDone),
		.csrCtrl    (csrCtrl),
		.expValid   (expValid),
		.expWord    (expWord),
		.doneCheck  (doneCheck),
		.expDone    (expDone),
		.csrCheck   (csrCheck),
		.expCsr     (expCsr),
		.errorCount (checkErrors),
		.doneCount  (doneCount)
	);

	// ------------------------------
	// SPI master driver
	// ------------------------------
	task automatic waitCycles(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge iSCLK);
		end
	endtask

	// Mode 0, data set while SCK low
	task automatic sendBit(input logic b);
		spiMosi <= b;
		waitCycles(HALF_PERIOD);
		spiSck <= 1'b1;
		waitCycles(HALF_PERIOD);
		spiSck <= 1'b0;
	endtask

	task automatic closeFrame();
		waitCycles(HALF_PERIOD);
		spiCs    <= 1'b1;
		expValid <= 1'b0;
		waitCycles(4 * HALF_PERIOD);
	endtask

	// Short bit count cuts the header and closes the frame
	task automatic sendHeader(input logic [31:0] addr, input int cmd, input int len,
		input int bits);
		logic [63:0] header;
		header = {addr, 8'h00, cmd[7:0], len[15:0]};
		spiCs <= 1'b0;
		waitCycles(HALF_PERIOD);
		for (int i = 0; i < bits; i++)
		begin
			sendBit(header[63 - i]);
		end
		if (bits >= 64)
		begin
			waitCycles(HDR_GAP);
		end
		else
		begin
			closeFrame();
		end
	endtask

	task automatic sendDataWord(input logic [`SPI_LINK_WORD_BITS-1:0] word, input logic check,
		input logic [`SPI_LINK_WORD_BITS-1:0] expected);
		expValid <= check;
		expWord  <= expected;
		for (int i = `SPI_LINK_WORD_BITS - 1; i >= 0; i--)
		begin
			sendBit(word[i]);
		end
	endtask

	// Wait on the opDone count, then have the checker compare it
	task automatic waitDoneCount(input int n);
		int waited;
		waited = 0;
		while ((doneCount < n) && (waited < DONE_WAIT))
		begin
			@(posedge iSCLK);
			waited++;
		end
		if (doneCount < n)
		begin
			$display("Timed out waiting for opDone count %0d", n);
			driverErrors++;
		end
		expDone   <= n;
		doneCheck <= 1'b1;
		@(posedge iSCLK);
		doneCheck <= 1'b0;
	endtask

	task automatic checkCsr(input logic [`SPI_LINK_WORD_BITS-1:0] value);
		expCsr   <= value;
		csrCheck <= 1'b1;
		@(posedge iSCLK);
		csrCheck <= 1'b0;
	endtask

	// ------------------------------
	// Watchdog
	// ------------------------------
	initial
	begin
		for (int c = 0; c < WATCHDOG_CYCLES; c++)
		begin
			@(posedge iSCLK);
		end
		$display("Watchdog expired, the test sequence did not finish");
		$display("Some tests failed");
		$finish;
	end

	// ------------------------------
	// Data file sequencer
	// ------------------------------
	initial
	begin
		int                             fd;
		int                             code;
		int                             ch;
		int                             cmd;
		int                             len;
		int                             hdrBits;
		int                             count;
		logic                           running;
		logic [63:0]                    token;
		logic [31:0]                    addr;
		logic [`SPI_LINK_WORD_BITS-1:0] word;
		iSRST        = 1'b1;
		spiSck       = 1'b0;
		spiMosi      = 1'b0;
		spiCs        = 1'b1;
		expValid     = 1'b0;
		expWord      = '0;
		doneCheck    = 1'b0;
		expDone      = 0;
		csrCheck     = 1'b0;
		expCsr       = '0;
		driverErrors = 0;
		seed         = 32'h903e2e55;
		running      = 1'b1;
		waitCycles(10);
		iSRST <= 1'b0;
		waitCycles(10);
		fd = $fopen("tb/spiLink_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the test data file");
			driverErrors++;
			running = 1'b0;
		end
		while (running)
		begin
			token = '0;
			code  = $fscanf(fd, "%s", token);
			if (code != 1)
			begin
				running = 1'b0;
			end
			else
			begin
				case (token)
					64'("#"):
					begin
						// Skip the rest of a comment line
						ch = $fgetc(fd);
						while ((ch != 10) && (ch != -1))
						begin
							ch = $fgetc(fd);
						end
					end
					64'("frame"):
					begin
						code = $fscanf(fd, "%h %d %d %d", addr, cmd, len, hdrBits);
						sendHeader(addr, cmd, len, hdrBits);
					end
					64'("wr"):
					begin
						code = $fscanf(fd, "%h", word);
						sendDataWord(word, 1'b0, '0);
					end
					64'("rnd"):
					begin
						code = $fscanf(fd, "%d", count);
						for (int k = 0; k < count; k++)
						begin
							word = $random(seed);
							randQueue.push_back(word);
							sendDataWord(word, 1'b0, '0);
						end
					end
					64'("rd"):
					begin
						code = $fscanf(fd, "%h", word);
						sendDataWord('0, 1'b1, word);
					end
					64'("rdq"):
					begin
						code = $fscanf(fd, "%d", count);
						for (int k = 0; k < count; k++)
						begin
							if (randQueue.size() == 0)
							begin
								$display("Data file reads more random words than were sent");
								driverErrors++;
							end
							else
							begin
								sendDataWord('0, 1'b1, randQueue.pop_front());
							end
						end
					end
					64'("end"):
					begin
						closeFrame();
					end
					64'("done"):
					begin
						code = $fscanf(fd, "%d", count);
						waitDoneCount(count);
					end
					64'("csr"):
					begin
						code = $fscanf(fd, "%h", word);
						checkCsr(word);
					end
					default:
					begin
						$display("Unknown record in the test data file");
						driverErrors++;
						running = 1'b0;
					end
				endcase
			end
		end
		if (fd != 0)
		begin
			$fclose(fd);
		end
		waitCycles(10);
		$display("Checker errors: %0d, driver errors: %0d", checkErrors, driverErrors);
		if ((checkErrors + driverErrors) == 0)
		begin
			$display("All tests passed");
		end
		else
		begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/spiLink_testdata.txt
# frame addrHex cmd len hdrBits | wr wordHex | rnd count | rd expectHex | rdq count | end
# checks: done opDoneCountSoFar | csr expectHex ; cmd 1 CSR wr, 2 CSR rd, 3 RAM wr, 4 RAM rd
# CSR write to index 0, length field ignored, second word dropped
frame 00000000 1 40 64
wr a5c30f1e
wr 12345678
end
frame 00000000 2 0 64
rd a5c30f1e
end
csr a5c30f1e
done 2
# Eight random words into RAM from address 20, read back in order, then all ones
frame 00000014 3 32 64
rnd 8
end
frame 00000014 4 32 64
rdq 8
rd ffffffff
end
done 4
# Length 8 keeps two of three words, third location stays zero
frame 00000064 3 8 64
wr 11111111
wr 22222222
wr 33333333
end
frame 00000064 4 12 64
rd 11111111
rd 22222222
rd 00000000
rd ffffffff
end
done 6
# Header cut after 20 bits gives no opDone
frame 00000000 3 4 20
done 6
# Command none moves nothing
frame 00000030 0 16 64
wr deadbeef
end
done 6
# Address 300 wraps to RAM index 44
frame 0000012c 3 4 64
wr 0badcafe
end
frame 0000002c 4 4 64
rd 0badcafe
end
done 8
csr a5c30f1e
